// ==== lsu.sv ====
`timescale 1ns/1ps

module lsu import rv_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mem_op_e         mem_op,
    input  logic            store_en,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_data,
    output logic [XLEN-1:0] load_data
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;        // doubleword index
    logic [7:0]       byte_mask;
    logic [XLEN-1:0]  wr_data;    // store data replicated into lanes
    logic [XLEN-1:0]  rd_dword;
    logic [31:0]      rd_word;
    logic [7:0]       rd_byte;

    assign idx = addr[3 +: IDX_W];

    // byte lanes for each store size, misaligned low bits simply ignored
    always_comb begin
        byte_mask = 8'h00;
        wr_data   = store_data;
        case (mem_op)
            MEM_SD: byte_mask = 8'hff;
            MEM_SW: begin
                byte_mask = addr[2] ? 8'hf0 : 8'h0f;
                wr_data   = {2{store_data[31:0]}};
            end
            MEM_SB: begin
                byte_mask = 8'h01 << addr[2:0];
                wr_data   = {8{store_data[7:0]}};
            end
            default: byte_mask = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;  // memory reads zero out of reset
            end
        end else if (store_en) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_mask[b]) begin
                    mem[idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    assign rd_dword = mem[idx];
    assign rd_word  = addr[2] ? rd_dword[63:32] : rd_dword[31:0];
    assign rd_byte  = rd_dword[{addr[2:0], 3'b000} +: 8];

    always_comb begin
        case (mem_op)
            MEM_LD:  load_data = rd_dword;
            MEM_LW:  load_data = {{(XLEN-32){rd_word[31]}}, rd_word};
            MEM_LBU: load_data = {{(XLEN-8){1'b0}}, rd_byte};
            default: load_data = '0;
        endcase
    end

    // upper address bits are dropped by idx, so catch accesses past the end
    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_op != MEM_NONE) |-> (addr[XLEN-1:3] < MEM_WORDS)
    ) else $error("lsu: doubleword index beyond MEM_WORDS");

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin  // x0 is read only
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

    // the storage behind x0 must never pick up a value, whatever is written
    a_x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    ) else $error("reg_file: x0 storage holds a nonzero value");

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    logic [5:0]  shamt;   // rv64 shifts use six bits
    logic [31:0] sum_w;   // low word sum for addw/addiw

    assign shamt = b[5:0];
    assign sum_w = a[31:0] + b[31:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;  // logical, zero fill
            ALU_ADDW: result = {{(XLEN-32){sum_w[31]}}, sum_w};
            default:  result = '0;
        endcase
    end

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  logic [31:0] instr,
    output dec_op_t     op,
    output logic        illegal
);

    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;

    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    // I- and S-format immediates, sign bit is always instr[31]
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        op           = '0;
        op.rs1       = instr[19:15];
        op.rs2       = instr[24:20];
        op.rd        = instr[11:7];
        op.imm       = imm_i;
        op.alu_op    = ALU_ADD;  // address and link paths all add
        op.mem_op    = MEM_NONE;
        op.wb_sel    = WB_ALU;
        illegal      = 1'b0;

        case (instr[6:0])
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: op.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: op.alu_op = ALU_SLL;
                    {7'b0000000, 3'b100}: op.alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: op.alu_op = ALU_SRL;
                    {7'b0000000, 3'b110}: op.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: op.alu_op = ALU_AND;
                    default:              illegal   = 1'b1;
                endcase
                op.reg_write = !illegal;
            end
            OPC_OP_IMM: begin
                op.use_imm   = 1'b1;
                illegal      = (funct3 != 3'b000);  // addi only
                op.reg_write = !illegal;
            end
            OPC_OP_32: begin
                op.alu_op    = ALU_ADDW;
                illegal      = ({funct7, funct3} != 10'b0);
                op.reg_write = !illegal;
            end
            OPC_OP_IMM_32: begin
                op.alu_op    = ALU_ADDW;  // addiw
                op.use_imm   = 1'b1;
                illegal      = (funct3 != 3'b000);
                op.reg_write = !illegal;
            end
            OPC_LOAD: begin
                op.use_imm = 1'b1;
                op.wb_sel  = WB_LOAD;
                case (funct3)
                    3'b011:  op.mem_op = MEM_LD;
                    3'b010:  op.mem_op = MEM_LW;
                    3'b100:  op.mem_op = MEM_LBU;
                    default: illegal   = 1'b1;
                endcase
                op.reg_write = !illegal;
            end
            OPC_STORE: begin
                op.use_imm = 1'b1;
                op.imm     = imm_s;
                case (funct3)
                    3'b011:  op.mem_op = MEM_SD;
                    3'b010:  op.mem_op = MEM_SW;
                    3'b000:  op.mem_op = MEM_SB;
                    default: illegal   = 1'b1;
                endcase
            end
            OPC_JALR: begin
                op.use_imm   = 1'b1;
                op.wb_sel    = WB_LINK;
                illegal      = (funct3 != 3'b000);
                op.reg_write = !illegal;
                op.is_jalr   = !illegal;
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin
            op.mem_op = MEM_NONE;  // never touch memory on a bad encoding
        end
    end

endmodule

// ==== rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core import rv_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    input  logic [XLEN-1:0] pc,
    output logic            commit_valid,
    output commit_t         commit,
    output redirect_t       redirect
);

    dec_op_t         dec_op;
    logic            illegal;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] link_addr;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] jalr_target;
    logic            rf_wen;
    logic            store_en;
    mem_op_e         lsu_op;
    commit_t         commit_d;
    logic            redirect_valid_q;
    logic [XLEN-1:0] redirect_target_q;

    rv_decoder u_decoder (
        .instr   (instr),
        .op      (dec_op),
        .illegal (illegal)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (rf_wen),
        .waddr  (dec_op.rd),
        .wdata  (wb_data),
        .raddr1 (dec_op.rs1),
        .raddr2 (dec_op.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign alu_b = dec_op.use_imm ? dec_op.imm : rs2_data;

    rv_alu u_alu (
        .alu_op (dec_op.alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result)
    );

    assign lsu_op   = instr_valid ? dec_op.mem_op : MEM_NONE;  // idle cycles stay quiet
    assign store_en = instr_valid && !illegal;

    lsu #(
        .MEM_WORDS (MEM_WORDS)
    ) u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_op     (lsu_op),
        .store_en   (store_en),
        .addr       (alu_result),  // alu sum is the effective address
        .store_data (rs2_data),
        .load_data  (load_data)
    );

    assign link_addr   = pc + XLEN'(4);
    assign jalr_target = {alu_result[XLEN-1:1], 1'b0};  // uses rs1 before writeback

    always_comb begin
        case (dec_op.wb_sel)
            WB_LOAD: wb_data = load_data;
            WB_LINK: wb_data = link_addr;
            default: wb_data = alu_result;
        endcase
    end

    assign rf_wen = instr_valid && dec_op.reg_write && !illegal && (dec_op.rd != '0);

    // commit shows the architectural write intent, even for rd == x0
    assign commit_d = '{
        pc:      pc,
        rd:      dec_op.rd,
        we:      dec_op.reg_write && !illegal,
        wdata:   wb_data,
        illegal: illegal
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid     <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            commit_valid     <= instr_valid;
            redirect_valid_q <= instr_valid && dec_op.is_jalr && !illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            commit            <= commit_d;
            redirect_target_q <= jalr_target;
        end
    end

    assign redirect = '{valid: redirect_valid_q, target: redirect_target_q};

    // a redirect only comes from a jalr, which always links
    a_redirect_with_commit: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.valid |-> (commit_valid && commit.we && !commit.illegal)
    ) else $error("rv_exec_core: redirect raised without a linking commit");

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 64; // data path width
    localparam int REG_ADDR_W = 5;  // 32 integer registers

    // major opcodes handled by this slice
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011,
        OPC_JALR      = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_ADDW  // 32-bit add, sign-extended
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LD,
        MEM_LW,
        MEM_LBU,
        MEM_SD,
        MEM_SW,
        MEM_SB
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK   // pc + 4 for jalr
    } wb_sel_e;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;       // already sign-extended
        logic                  use_imm;   // imm replaces rs2 at the alu
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        wb_sel_e               wb_sel;
        logic                  reg_write;
        logic                  is_jalr;
    } dec_op_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       wdata;
        logic                  illegal;
    } commit_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== sources.f ====
rv_pkg.sv
rv_decoder.sv
reg_file.sv
rv_alu.sv
lsu.sv
rv_exec_core.sv
tb_rv_exec_core.sv

// ==== tb_rv_exec_core.sv ====
`timescale 1ns/1ps

module tb_rv_exec_core import rv_pkg::*; ();

    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTRS   = 88;  // strobes issued over all six tests
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * NUM_INSTRS + 20;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic            commit_valid;
    commit_t         commit;
    redirect_t       redirect;

    logic [XLEN-1:0] model_regs [32];        // reference register state
    logic [XLEN-1:0] model_mem [MEM_WORDS];  // reference data memory
    logic [XLEN-1:0] next_pc;
    int value_errors = 0;
    int other_errors = 0;
    int issued       = 0;
    int commits_seen = 0;
    int cycles       = 0;

    rv_exec_core #(.MEM_WORDS(MEM_WORDS)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .commit_valid (commit_valid),
        .commit       (commit),
        .redirect     (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n && commit_valid === 1'b1) commits_seen++;  // every commit, idle or not
    end

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    // sel picks add, sub, and, or, xor, sll, srl
    function automatic logic [31:0] arith_instr(input int sel, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'b0000000;
        case (sel)
            0:       f3 = 3'b000;
            1: begin
                f7 = 7'b0100000;
                f3 = 3'b000;
            end
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            4:       f3 = 3'b100;
            5:       f3 = 3'b001;
            default: f3 = 3'b101;
        endcase
        return r_format(f7, rs2, rs1, f3, rd, 7'b0110011);
    endfunction

    // reference model, follows the RV64I rules and updates its own state
    task automatic predict(input logic [31:0] ins, input logic [XLEN-1:0] ipc,
            output commit_t exp, output logic exp_redir, output logic [XLEN-1:0] exp_target);
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [31:0]     w;
        logic            illegal;
        logic            we;
        int              idx;
        rd        = ins[11:7];
        a         = (ins[19:15] == 5'd0) ? '0 : model_regs[ins[19:15]];
        b         = (ins[24:20] == 5'd0) ? '0 : model_regs[ins[24:20]];
        imm_i     = {{52{ins[31]}}, ins[31:20]};
        imm_s     = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        illegal   = 1'b0;
        we        = 1'b1;
        wdata     = '0;
        exp_redir = 1'b0;
        exp_target = '0;
        case (ins[6:0])
            7'b0110011: begin
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: wdata = a + b;
                    10'b0100000_000: wdata = a - b;
                    10'b0000000_001: wdata = a << b[5:0];
                    10'b0000000_100: wdata = a ^ b;
                    10'b0000000_101: wdata = a >> b[5:0];
                    10'b0000000_110: wdata = a | b;
                    10'b0000000_111: wdata = a & b;
                    default:         illegal = 1'b1;
                endcase
            end
            7'b0010011: begin
                illegal = (ins[14:12] != 3'b000);
                wdata   = a + imm_i;
            end
            7'b0111011, 7'b0011011: begin
                illegal = (ins[14:12] != 3'b000) || (ins[5] && ins[31:25] != 7'b0);
                w       = a[31:0] + (ins[5] ? b[31:0] : imm_i[31:0]);
                wdata   = {{32{w[31]}}, w};
            end
            7'b0000011: begin
                addr = a + imm_i;
                idx  = int'(addr >> 3);
                w    = addr[2] ? model_mem[idx][63:32] : model_mem[idx][31:0];
                case (ins[14:12])
                    3'b011:  wdata = model_mem[idx];
                    3'b010:  wdata = {{32{w[31]}}, w};
                    3'b100:  wdata = {56'b0, model_mem[idx][addr[2:0]*8 +: 8]};
                    default: illegal = 1'b1;
                endcase
            end
            7'b0100011: begin
                we   = 1'b0;
                addr = a + imm_s;
                idx  = int'(addr >> 3);
                case (ins[14:12])
                    3'b011: model_mem[idx] = b;
                    3'b010: begin
                        if (addr[2]) model_mem[idx][63:32] = b[31:0];
                        else         model_mem[idx][31:0]  = b[31:0];
                    end
                    3'b000:  model_mem[idx][addr[2:0]*8 +: 8] = b[7:0];
                    default: illegal = 1'b1;
                endcase
            end
            7'b1100111: begin
                illegal    = (ins[14:12] != 3'b000);
                wdata      = ipc + 64'd4;
                exp_redir  = !illegal;
                exp_target = (a + imm_i) & ~64'd1;  // old rs1, bit 0 cleared
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) we = 1'b0;
        if (we && rd != 5'd0) model_regs[rd] = wdata;
        exp         = '0;
        exp.pc      = ipc;
        exp.rd      = rd;
        exp.we      = we;
        exp.wdata   = wdata;
        exp.illegal = illegal;
    endtask

    task automatic compare(input string name, input logic [XLEN-1:0] got,
            input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_commit(input commit_t exp, input logic exp_redir,
            input logic [XLEN-1:0] exp_target);
        compare("commit_valid", commit_valid, 1);
        compare("commit.pc", commit.pc, exp.pc);
        compare("commit.illegal", commit.illegal, exp.illegal);
        compare("commit.we", commit.we, exp.we);
        if (exp.we) begin
            compare("commit.rd", commit.rd, exp.rd);
            compare("commit.wdata", commit.wdata, exp.wdata);
        end
        compare("redirect.valid", redirect.valid, exp_redir);
        if (exp_redir) compare("redirect.target", redirect.target, exp_target);
    endtask

    // called at a falling edge, returns at the next one with the commit checked
    task automatic run_instr(input logic [31:0] ins);
        commit_t         exp;
        logic            exp_redir;
        logic [XLEN-1:0] exp_target;
        predict(ins, next_pc, exp, exp_redir, exp_target);
        instr_valid = 1'b1;
        instr       = ins;
        pc          = next_pc;
        issued++;
        @(negedge clk);
        instr_valid = 1'b0;
        next_pc     = exp_redir ? exp_target : next_pc + 64'd4;  // fetch follows redirect
        check_commit(exp, exp_redir, exp_target);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        compare("commit_valid", commit_valid, 0);
        compare("redirect.valid", redirect.valid, 0);
    endtask

    task automatic random_arith(input int count);
        for (int k = 0; k < count; k++) begin
            run_instr(arith_instr($urandom_range(6, 0), 5'($urandom_range(15, 1)),
                5'($urandom_range(15, 1)), 5'($urandom_range(15, 1))));
        end
    endtask

    task automatic test_arith();
        for (int r = 1; r <= 8; r++) begin
            run_instr(i_format(12'($urandom()), 5'd0, 3'b000, 5'(r), OPC_OP_IMM));
        end
        random_arith(20);
        idle_cycle();
    endtask

    task automatic test_word();
        run_instr(i_format(12'h7ff, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        run_instr(i_format(12'd20, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        run_instr(arith_instr(5, 5'd1, 5'd1, 5'd2));  // x1 = 0x7ff00000
        run_instr(r_format(7'b0, 5'd1, 5'd1, 3'b000, 5'd3, OPC_OP_32));
        compare("commit.wdata", commit.wdata, 64'hffff_ffff_ffe0_0000);
        run_instr(i_format(12'hfff, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
        run_instr(i_format(12'd33, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        run_instr(arith_instr(6, 5'd6, 5'd6, 5'd2));  // x6 = 0x7fffffff
        run_instr(i_format(12'd1, 5'd6, 3'b000, 5'd7, OPC_OP_IMM_32));
        compare("commit.wdata", commit.wdata, 64'hffff_ffff_8000_0000);
        run_instr(r_format(7'b0, 5'd6, 5'd6, 3'b000, 5'd8, OPC_OP_32));
        compare("commit.wdata", commit.wdata, 64'hffff_ffff_ffff_fffe);
        for (int k = 0; k < 4; k++) begin
            run_instr(r_format(7'b0, 5'($urandom_range(15, 1)), 5'($urandom_range(15, 1)),
                3'b000, 5'($urandom_range(20, 16)), OPC_OP_32));
            run_instr(i_format(12'($urandom()), 5'($urandom_range(15, 1)), 3'b000,
                5'($urandom_range(20, 16)), OPC_OP_IMM_32));
        end
        idle_cycle();
    endtask

    task automatic test_x0();
        run_instr(i_format(12'h123, 5'd5, 3'b000, 5'd0, OPC_OP_IMM));
        compare("commit.rd", commit.rd, 0);
        run_instr(arith_instr(0, 5'd9, 5'd0, 5'd5));
        compare("commit.wdata", commit.wdata, model_regs[5]);  // x0 still reads zero
        idle_cycle();
    endtask

    task automatic test_mem();
        logic [11:0] offs;
        run_instr(i_format(12'h100, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        run_instr(s_format(12'd0, 5'd3, 5'd10, 3'b011, OPC_STORE));
        run_instr(i_format(12'd0, 5'd10, 3'b011, 5'd11, OPC_LOAD));
        compare("commit.wdata", commit.wdata, model_regs[3]);
        run_instr(s_format(12'd8, 5'd7, 5'd10, 3'b010, OPC_STORE));
        run_instr(s_format(12'd12, 5'd6, 5'd10, 3'b010, OPC_STORE));
        run_instr(s_format(12'd9, 5'd2, 5'd10, 3'b000, OPC_STORE));
        run_instr(s_format(12'd15, 5'd8, 5'd10, 3'b000, OPC_STORE));
        run_instr(i_format(12'd8, 5'd10, 3'b011, 5'd11, OPC_LOAD));
        run_instr(i_format(12'd8, 5'd10, 3'b010, 5'd12, OPC_LOAD));
        compare("commit.wdata", commit.wdata, 64'hffff_ffff_8000_2100);
        run_instr(i_format(12'd12, 5'd10, 3'b010, 5'd13, OPC_LOAD));
        run_instr(i_format(12'd9, 5'd10, 3'b100, 5'd14, OPC_LOAD));
        run_instr(i_format(12'd15, 5'd10, 3'b100, 5'd15, OPC_LOAD));
        compare("commit.wdata", commit.wdata, 64'h0000_0000_0000_00fe);
        for (int k = 0; k < 4; k++) begin
            offs = 12'(16 + $urandom_range(7, 0));
            run_instr(s_format(offs, 5'($urandom_range(15, 1)), 5'd10, 3'b000, OPC_STORE));
            run_instr(i_format(offs, 5'd10, 3'b100, 5'($urandom_range(20, 16)), OPC_LOAD));
        end
        idle_cycle();
    endtask

    task automatic test_jalr();
        run_instr(i_format(12'h205, 5'd0, 3'b000, 5'd21, OPC_OP_IMM));
        run_instr(i_format(12'd8, 5'd21, 3'b000, 5'd22, OPC_JALR));
        compare("redirect.target", redirect.target, 64'h20c);
        run_instr(i_format(12'd3, 5'd21, 3'b000, 5'd21, OPC_JALR));  // rd equals rs1
        compare("redirect.target", redirect.target, 64'h208);
        run_instr(i_format(12'd0, 5'd21, 3'b000, 5'd23, OPC_OP_IMM));
        run_instr(i_format(12'd0, 5'd22, 3'b000, 5'd0, OPC_JALR));
        idle_cycle();
    endtask

    task automatic test_illegal_burst();
        run_instr({20'habcde, 5'd5, 7'b1111111});  // unknown opcode, rd = x5
        compare("commit.illegal", commit.illegal, 1);
        run_instr(arith_instr(0, 5'd24, 5'd5, 5'd0));
        run_instr(s_format(12'd0, 5'd8, 5'd10, 3'b001, OPC_STORE));  // sh is not supported
        run_instr(i_format(12'd0, 5'd10, 3'b011, 5'd25, OPC_LOAD));
        run_instr(i_format(12'h055, 5'd1, 3'b010, 5'd6, OPC_OP_IMM));  // slti is not supported
        run_instr(arith_instr(0, 5'd26, 5'd6, 5'd0));
        random_arith(10);
        idle_cycle();
        assert (commits_seen == issued) else begin
            other_errors++;
            $display("commit count mismatch: %0d strobes issued but %0d commits seen",
                issued, commits_seen);
        end
    endtask

    initial begin
        void'($urandom(39));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        next_pc     = 64'h1000;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        for (int w = 0; w < MEM_WORDS; w++) model_mem[w] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        compare("commit_valid", commit_valid, 0);
        compare("redirect.valid", redirect.valid, 0);
        test_arith();
        test_word();
        test_x0();
        test_mem();
        test_jalr();
        test_illegal_burst();
        $display("errors: %0d value mismatches, %0d other failures",
            value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
